// ==== jts16_game.f ====
rtl/jts16_pkg.sv
rtl/jts16_cen.sv
rtl/jts16_vtimer.sv
rtl/jts16_char.sv
rtl/jts16_sdram.sv
rtl/jts16_game.sv
verif/jts16_game_assert.sv
verif/jts16_game_tb.sv

// ==== Makefile ====
TOP = jts16_game_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f jts16_game.f --top-module $(TOP)

run: build
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "Everything OK"

lint:
	verilator --lint-only -Wall --timing -f jts16_game.f --top-module $(TOP)

clean:
	rm -rf obj_dir

// ==== verif/jts16_game_tb.sv ====
// Testbench for the video subsystem with SDRAM bank model, table-driven main reads and pixel checks
`timescale 1ns/1ps
`default_nettype none

module jts16_game_tb;

    localparam int H_ACTIVE = 64;
    localparam int H_TOTAL  = 96;
    localparam int V_ACTIVE = 32;
    localparam int V_TOTAL  = 40;
    localparam int FRAME_CLK = H_TOTAL * V_TOTAL * 4;
    localparam int LINE_CLK  = H_TOTAL * 4;
    localparam int NUM_READS = 8;
    localparam int MAX_CYCLES = 3 * FRAME_CLK + 2000 * NUM_READS;

    typedef struct packed {
        jts16_pkg::cpu_addr_t addr;
        logic [11:0]          hold;
        logic                 gfx;
    } read_entry_t;

    // Main address, cycles main_cs is held after main_ok, gfx_en of the frame
    localparam read_entry_t READS [NUM_READS] = '{
        '{17'h00012, 12'd1200, 1'b1},
        '{17'h0a5f3, 12'd900,  1'b1},
        '{17'h1ffff, 12'd1500, 1'b1},
        '{17'h04000, 12'd700,  1'b1},
        '{17'h00001, 12'd800,  1'b0},
        '{17'h13579, 12'd1100, 1'b0},
        '{17'h0beef, 12'd600,  1'b0},
        '{17'h10000, 12'd1000, 1'b0}
    };

    logic                   clk;
    logic                   rst_n;
    logic                   gfx_en;
    logic                   main_cs;
    jts16_pkg::cpu_addr_t   main_addr;
    jts16_pkg::sdram_data_t main_data;
    logic                   main_ok;
    jts16_pkg::sdram_addr_t ba_addr;
    logic                   ba_rd;
    logic                   ba_ack;
    logic                   ba_rdy;
    jts16_pkg::sdram_data_t data_read;
    logic                   refresh_en;
    logic [4:0]             red;
    logic [4:0]             green;
    logic [4:0]             blue;
    logic                   LHBL_dly;
    logic                   LVBL_dly;
    logic                   HS;
    logic                   VS;

    int errors = 0;
    int cyc = 0;

    jts16_game #(
        .H_ACTIVE ( H_ACTIVE ),
        .H_TOTAL  ( H_TOTAL  ),
        .V_ACTIVE ( V_ACTIVE ),
        .V_TOTAL  ( V_TOTAL  )
    ) jts16_game_i (
        .clk        ( clk        ),
        .rst_n      ( rst_n      ),
        .gfx_en     ( gfx_en     ),
        .main_cs    ( main_cs    ),
        .main_addr  ( main_addr  ),
        .main_data  ( main_data  ),
        .main_ok    ( main_ok    ),
        .ba_addr    ( ba_addr    ),
        .ba_rd      ( ba_rd      ),
        .ba_ack     ( ba_ack     ),
        .ba_rdy     ( ba_rdy     ),
        .data_read  ( data_read  ),
        .refresh_en ( refresh_en ),
        .red        ( red        ),
        .green      ( green      ),
        .blue       ( blue       ),
        .LHBL_dly   ( LHBL_dly   ),
        .LVBL_dly   ( LVBL_dly   ),
        .HS         ( HS         ),
        .VS         ( VS         )
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Content of every bank word
    function automatic jts16_pkg::sdram_data_t bank_word(input jts16_pkg::sdram_addr_t a);
        return a[15:0] ^ 16'h5a3c;
    endfunction

    function automatic jts16_pkg::rgb_t expect_pixel(input int row, input int col,
                                                     input logic gfx);
        jts16_pkg::sdram_addr_t map_a;
        jts16_pkg::sdram_addr_t gfx_a;
        jts16_pkg::sdram_data_t map_w;
        jts16_pkg::sdram_data_t row_w;
        logic [9:0]             code;
        jts16_pkg::pxl_t        idx;
        map_a = jts16_pkg::MAP_BASE
              + jts16_pkg::sdram_addr_t'((row / 8) * (H_ACTIVE / 8) + col / 8);
        map_w = bank_word(map_a);
        code  = map_w[9:0];
        gfx_a = jts16_pkg::GFX_BASE + jts16_pkg::sdram_addr_t'(code) * 22'd8
              + jts16_pkg::sdram_addr_t'(row % 8);
        row_w = bank_word(gfx_a);
        idx   = row_w[15 - 2 * (col % 8) -: 2];
        return gfx ? jts16_pkg::PALETTE[idx] : jts16_pkg::PALETTE[0];
    endfunction

    // SDRAM bank model, ack after 1 to 3 cycles and data 2 cycles later
    int                     bank_phase;
    int                     bank_wait;
    jts16_pkg::sdram_addr_t bank_addr;

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ba_ack     <= 1'b0;
            ba_rdy     <= 1'b0;
            data_read  <= '0;
            bank_phase <= 0;
            bank_wait  <= 0;
        end else begin
            ba_ack <= 1'b0;
            ba_rdy <= 1'b0;
            case (bank_phase)
                0: if (ba_rd) begin
                    bank_wait  <= $urandom_range(3, 1);
                    bank_addr  <= ba_addr;
                    bank_phase <= 1;
                end
                1: if (bank_wait <= 1) begin
                    ba_ack     <= 1'b1;
                    bank_wait  <= 2;
                    bank_phase <= 2;
                end else begin
                    bank_wait <= bank_wait - 1;
                end
                default: if (bank_wait <= 1) begin
                    ba_rdy     <= 1'b1;
                    data_read  <= bank_word(bank_addr);
                    bank_phase <= 0;
                end else begin
                    bank_wait <= bank_wait - 1;
                end
            endcase
        end
    end

    // Output monitor, all values sampled on the rising edge
    logic prev_lhbl = 1'b0;
    logic prev_lvbl = 1'b0;
    logic prev_hs = 1'b0;
    logic prev_vs = 1'b0;
    logic frame_gfx = 1'b0;
    logic refresh_seen = 1'b0;
    logic hs_done = 1'b0;
    logic vs_done = 1'b0;
    int   frames = 0;
    int   row = 0;
    int   col = 0;
    int   sub = 0;
    int   pix_checked = 0;
    int   refresh_run = 0;
    int   lhbl_fall_cyc = -1;
    int   lvbl_fall_cyc = -1;
    int   hs_rise_cyc = -1;
    int   vs_rise_cyc = -1;
    jts16_pkg::rgb_t exp_rgb;

    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (rst_n) begin
            if (!LHBL_dly || !LVBL_dly) begin
                assert ({red, green, blue} == jts16_pkg::PALETTE[0]) else begin
                    errors++;
                    $display("[ERROR] %0t: blanked pixel %h is not backdrop", $time,
                             {red, green, blue});
                end
            end
            // A new frame starts with the first visible line
            if (LVBL_dly && !prev_lvbl) begin
                if (frames >= 1) begin
                    assert (refresh_seen) else begin
                        errors++;
                        $display("[ERROR] %0t: no refresh_en in vertical blank", $time);
                    end
                end
                refresh_seen = 1'b0;
                frames++;
                frame_gfx = gfx_en;
            end
            if (LHBL_dly && !prev_lhbl) begin
                row = (LVBL_dly && !prev_lvbl) ? 0 : row + 1;
                col = 0;
                sub = 0;
            end else if (sub == 3) begin
                sub = 0;
                col++;
            end else begin
                sub++;
            end
            if (LHBL_dly && LVBL_dly && sub == 0 && frames >= 2) begin
                exp_rgb = expect_pixel(row, col, frame_gfx);
                pix_checked++;
                assert ({red, green, blue} == exp_rgb) else begin
                    errors++;
                    $display("[ERROR] %0t: pixel row %0d col %0d is %h, expected %h",
                             $time, row, col, {red, green, blue}, exp_rgb);
                end
            end
            if (refresh_en && !LVBL_dly) refresh_seen = 1'b1;
            // LVBL_dly trails the timer by one pixel
            refresh_run = (refresh_en && LVBL_dly) ? refresh_run + 1 : 0;
            assert (refresh_run <= 4) else begin
                errors++;
                $display("[ERROR] %0t: refresh_en high in active video", $time);
            end
            if (!LHBL_dly && prev_lhbl && lhbl_fall_cyc < 0) lhbl_fall_cyc = cyc;
            if (!LVBL_dly && prev_lvbl && lvbl_fall_cyc < 0) lvbl_fall_cyc = cyc;
            if (HS && !prev_hs && !hs_done) begin
                if (hs_rise_cyc < 0) begin
                    hs_rise_cyc = cyc;
                    assert (cyc - lhbl_fall_cyc == 28) else begin
                        errors++;
                        $display("[ERROR] %0t: HS starts %0d clk after blank", $time,
                                 cyc - lhbl_fall_cyc);
                    end
                end else begin
                    hs_done = 1'b1;
                    assert (cyc - hs_rise_cyc == LINE_CLK) else begin
                        errors++;
                        $display("[ERROR] %0t: HS period %0d clk", $time, cyc - hs_rise_cyc);
                    end
                end
            end
            if (!HS && prev_hs && !hs_done) begin
                assert (cyc - hs_rise_cyc == 32) else begin
                    errors++;
                    $display("[ERROR] %0t: HS width %0d clk", $time, cyc - hs_rise_cyc);
                end
            end
            if (VS && !prev_vs && vs_rise_cyc < 0) begin
                vs_rise_cyc = cyc;
                assert (cyc - lvbl_fall_cyc == 2 * LINE_CLK - 4) else begin
                    errors++;
                    $display("[ERROR] %0t: VS starts %0d clk after blank", $time,
                             cyc - lvbl_fall_cyc);
                end
            end
            if (!VS && prev_vs && !vs_done) begin
                vs_done = 1'b1;
                assert (cyc - vs_rise_cyc == 2 * LINE_CLK) else begin
                    errors++;
                    $display("[ERROR] %0t: VS width %0d clk", $time, cyc - vs_rise_cyc);
                end
            end
        end
        prev_lhbl = LHBL_dly;
        prev_lvbl = LVBL_dly;
        prev_hs   = HS;
        prev_vs   = VS;
    end

    always @(posedge clk) begin
        if (cyc >= MAX_CYCLES) begin
            $display("Timeout after %0d clock cycles", cyc);
            $display("Something failed");
            $finish;
        end
    end

    task automatic main_read(input jts16_pkg::cpu_addr_t a, input int hold);
        jts16_pkg::sdram_data_t expected;
        expected = bank_word(jts16_pkg::MAIN_BASE + jts16_pkg::sdram_addr_t'(a));
        @(posedge clk);
        main_cs   <= 1'b1;
        main_addr <= a;
        do @(posedge clk); while (!main_ok);
        assert (main_data == expected) else begin
            errors++;
            $display("[ERROR] %0t: main read %h returned %h, expected %h", $time, a,
                     main_data, expected);
        end
        repeat (hold) begin
            @(posedge clk);
            assert (main_ok) else begin
                errors++;
                $display("[ERROR] %0t: main_ok dropped while main_cs held", $time);
            end
        end
        main_cs <= 1'b0;
        @(posedge clk);
        @(posedge clk);
        assert (!main_ok) else begin
            errors++;
            $display("[ERROR] %0t: main_ok still high after main_cs dropped", $time);
        end
    endtask

    initial begin
        void'($urandom(32'h26b8));
        rst_n     = 1'b0;
        gfx_en    = 1'b0;
        main_cs   = 1'b0;
        main_addr = '0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        @(posedge clk);
        assert (!ba_rd && !refresh_en && !main_ok) else begin
            errors++;
            $display("[ERROR] %0t: bank outputs not idle after reset", $time);
        end
        for (int i = 0; i < NUM_READS; i++) begin
            // gfx_en only changes in vertical blank
            if (READS[i].gfx != gfx_en) begin
                @(negedge LVBL_dly);
                @(posedge clk);
                gfx_en <= READS[i].gfx;
            end
            main_read(READS[i].addr, int'(READS[i].hold));
        end
        @(negedge LVBL_dly);
        @(posedge LVBL_dly);
        repeat (2) @(posedge clk);
        assert (pix_checked >= 2 * H_ACTIVE * V_ACTIVE) else begin
            errors++;
            $display("Only %0d active pixels were checked", pix_checked);
        end
        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verif/jts16_game_assert.sv ====
// Bank protocol assertions bound into the SDRAM arbiter
`timescale 1ns/1ps
`default_nettype none

module jts16_game_assert (
    input wire                         clk,
    input wire                         rst_n,
    input wire                         ba_rd,
    input wire                         ba_ack,
    input wire                         ba_rdy,
    input wire jts16_pkg::sdram_addr_t ba_addr,
    input wire                         refresh_en,
    input wire                         main_cs,
    input wire                         main_ok,
    input wire jts16_pkg::arb_st_e     st
);

    // Read request holds with a stable address until acknowledged
    rd_hold: assert property (@(posedge clk) disable iff (!rst_n)
        ba_rd && !ba_ack |=> ba_rd && $stable(ba_addr))
        else $error("ba_rd or ba_addr changed before ba_ack");

    no_refresh_on_rd: assert property (@(posedge clk) disable iff (!rst_n)
        !(refresh_en && ba_rd))
        else $error("refresh_en high together with ba_rd");

    ok_needs_cs: assert property (@(posedge clk) disable iff (!rst_n)
        main_ok |-> main_cs)
        else $error("main_ok high without main_cs");

    // Returned word only for the single acknowledged read in flight
    rdy_outstanding: assert property (@(posedge clk) disable iff (!rst_n)
        ba_rdy |-> !ba_rd && st != jts16_pkg::ST_IDLE)
        else $error("ba_rdy without an outstanding read");

endmodule

bind jts16_sdram jts16_game_assert jts16_game_assert_i (.*);

`default_nettype wire

// ==== rtl/jts16_game.sv ====
// Game top level wiring the strobes, video timer, character layer and SDRAM arbiter
`timescale 1ns/1ps
`default_nettype none

module jts16_game #(
    parameter int H_ACTIVE = 64,
    parameter int H_TOTAL  = 96,
    parameter int V_ACTIVE = 32,
    parameter int V_TOTAL  = 40
) (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire                         gfx_en,
    // Main CPU ROM port
    input  wire                         main_cs,
    input  wire jts16_pkg::cpu_addr_t   main_addr,
    output wire jts16_pkg::sdram_data_t main_data,
    output wire                         main_ok,
    // Read-only SDRAM bank
    output wire jts16_pkg::sdram_addr_t ba_addr,
    output wire                         ba_rd,
    input  wire                         ba_ack,
    input  wire                         ba_rdy,
    input  wire jts16_pkg::sdram_data_t data_read,
    output wire                         refresh_en,
    // Video out
    output wire [4:0]                   red,
    output wire [4:0]                   green,
    output wire [4:0]                   blue,
    output wire                         LHBL_dly,
    output wire                         LVBL_dly,
    output wire                         HS,
    output wire                         VS
);

    wire                      pxl_cen;
    wire                      LVBL;
    wire [8:0]                hdump;
    wire [8:0]                vdump;
    wire jts16_pkg::vid_t     vid;
    wire jts16_pkg::rgb_t     rgb;
    wire jts16_pkg::rom_req_t char_req;
    wire jts16_pkg::rom_rsp_t char_rsp;

    assign red   = rgb.red;
    assign green = rgb.green;
    assign blue  = rgb.blue;
    assign HS    = vid.hs;
    assign VS    = vid.vs;

    // No double-pixel user without scroll layers and sprites
    jts16_cen u_cen (
        .clk      ( clk     ),
        .rst_n    ( rst_n   ),
        .pxl2_cen (         ),
        .pxl_cen  ( pxl_cen )
    );

    jts16_vtimer #(
        .H_ACTIVE ( H_ACTIVE ),
        .H_TOTAL  ( H_TOTAL  ),
        .V_ACTIVE ( V_ACTIVE ),
        .V_TOTAL  ( V_TOTAL  )
    ) u_vtimer (
        .clk      ( clk     ),
        .rst_n    ( rst_n   ),
        .pxl_cen  ( pxl_cen ),
        .hdump    ( hdump   ),
        .vdump    ( vdump   ),
        .vid      ( vid     ),
        .LVBL     ( LVBL    )
    );

    jts16_char #(
        .H_ACTIVE ( H_ACTIVE ),
        .H_TOTAL  ( H_TOTAL  )
    ) u_char (
        .clk      ( clk      ),
        .rst_n    ( rst_n    ),
        .pxl_cen  ( pxl_cen  ),
        .hdump    ( hdump    ),
        .vdump    ( vdump    ),
        .vid      ( vid      ),
        .gfx_en   ( gfx_en   ),
        .rom_req  ( char_req ),
        .rom_rsp  ( char_rsp ),
        .rgb      ( rgb      ),
        .LHBL_dly ( LHBL_dly ),
        .LVBL_dly ( LVBL_dly )
    );

    jts16_sdram u_sdram (
        .clk        ( clk        ),
        .rst_n      ( rst_n      ),
        .LVBL       ( LVBL       ),
        .char_req   ( char_req   ),
        .char_rsp   ( char_rsp   ),
        .main_cs    ( main_cs    ),
        .main_addr  ( main_addr  ),
        .main_data  ( main_data  ),
        .main_ok    ( main_ok    ),
        .ba_addr    ( ba_addr    ),
        .ba_rd      ( ba_rd      ),
        .ba_ack     ( ba_ack     ),
        .ba_rdy     ( ba_rdy     ),
        .data_read  ( data_read  ),
        .refresh_en ( refresh_en )
    );

endmodule

`default_nettype wire

// ==== rtl/jts16_sdram.sv ====
// SDRAM arbiter sharing one read-only bank between the character layer and main CPU ROM
`timescale 1ns/1ps
`default_nettype none

module jts16_sdram (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire                         LVBL,
    input  wire jts16_pkg::rom_req_t    char_req,
    output jts16_pkg::rom_rsp_t         char_rsp,
    input  wire                         main_cs,
    input  wire jts16_pkg::cpu_addr_t   main_addr,
    output jts16_pkg::sdram_data_t      main_data,
    output logic                        main_ok,
    output jts16_pkg::sdram_addr_t      ba_addr,
    output logic                        ba_rd,
    input  wire                         ba_ack,
    input  wire                         ba_rdy,
    input  wire jts16_pkg::sdram_data_t data_read,
    output logic                        refresh_en
);

    jts16_pkg::arb_st_e     st;
    jts16_pkg::sdram_data_t char_data;
    logic                   char_ok;
    logic                   main_vld;
    logic                   char_pend;
    logic                   main_pend;
    logic                   done;

    // Char holds cs for one clk after ok, so ok masks it
    assign char_pend = char_req.cs && !char_ok;
    assign main_pend = main_cs && !main_vld;
    assign done      = ba_rdy && !ba_rd && (st != jts16_pkg::ST_IDLE);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            st       <= jts16_pkg::ST_IDLE;
            ba_rd    <= 1'b0;
            char_ok  <= 1'b0;
            main_vld <= 1'b0;
        end else begin
            char_ok <= 1'b0;
            if (!main_cs) main_vld <= 1'b0;
            case (st)
                jts16_pkg::ST_IDLE: begin
                    // Character layer first
                    if (char_pend) begin
                        ba_rd <= 1'b1;
                        st    <= jts16_pkg::ST_CHAR;
                    end else if (main_pend) begin
                        ba_rd <= 1'b1;
                        st    <= jts16_pkg::ST_MAIN;
                    end
                end
                default: begin
                    if (ba_ack) ba_rd <= 1'b0;
                    if (done) begin
                        st <= jts16_pkg::ST_IDLE;
                        if (st == jts16_pkg::ST_CHAR) begin
                            char_ok <= 1'b1;
                        end else begin
                            main_vld <= main_cs;
                        end
                    end
                end
            endcase
        end
    end

    // Address and returned words
    always_ff @(posedge clk) begin
        if (st == jts16_pkg::ST_IDLE) begin
            if (char_pend) begin
                ba_addr <= char_req.addr;
            end else if (main_pend) begin
                ba_addr <= jts16_pkg::MAIN_BASE + jts16_pkg::sdram_addr_t'(main_addr);
            end
        end
        if (done) begin
            if (st == jts16_pkg::ST_CHAR) begin
                char_data <= data_read;
            end else begin
                main_data <= data_read;
            end
        end
    end

    assign char_rsp = {char_ok, char_data};
    assign main_ok  = main_vld && main_cs;

    // Refresh only in vertical blank while the bank is quiet
    assign refresh_en = !LVBL && (st == jts16_pkg::ST_IDLE) && !char_pend && !main_pend;

endmodule

`default_nettype wire

// ==== rtl/jts16_char.sv ====
// Character layer that prefetches map and row words and shifts pixels out through the palette
`timescale 1ns/1ps
`default_nettype none

module jts16_char #(
    parameter int H_ACTIVE = 64,
    parameter int H_TOTAL  = 96
) (
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire                      pxl_cen,
    input  wire [8:0]                hdump,
    input  wire [8:0]                vdump,
    input  wire jts16_pkg::vid_t     vid,
    input  wire                      gfx_en,
    output jts16_pkg::rom_req_t      rom_req,
    input  wire jts16_pkg::rom_rsp_t rom_rsp,
    output jts16_pkg::rgb_t          rgb,
    output logic                     LHBL_dly,
    output logic                     LVBL_dly
);

    localparam jts16_pkg::sdram_addr_t MAP_W = jts16_pkg::sdram_addr_t'(H_ACTIVE / 8);
    localparam logic [8:0] LAST_FETCH_H = 9'(H_ACTIVE - 8);
    localparam logic [8:0] LINE_FETCH_H = 9'(H_TOTAL - 8);
    localparam logic [8:0] ACTIVE_H     = 9'(H_ACTIVE);

    logic                   cs;
    logic                   step;
    logic                   map_due;
    logic                   gfx_due;
    logic                   drop;
    logic                   nxt_vld;
    logic [5:0]             fcol;
    logic [8:0]             fline;
    logic [9:0]             code;
    logic [15:0]            shift;
    jts16_pkg::sdram_addr_t addr;
    jts16_pkg::sdram_addr_t map_addr;
    jts16_pkg::sdram_addr_t gfx_addr;
    jts16_pkg::sdram_data_t nxt_row;
    jts16_pkg::pxl_t        cur_pxl;
    jts16_pkg::pxl_t        pal_idx;
    logic                   tile_start;
    logic                   col_go;
    logic                   line_go;
    logic                   fetch_go;
    logic                   load;

    // Next tile of this line, or tile 0 of the next line near the end of blanking
    assign tile_start = (hdump[2:0] == 3'd0) && (hdump < ACTIVE_H);
    assign col_go     = (hdump[2:0] == 3'd0) && (hdump < LAST_FETCH_H);
    assign line_go    = hdump == LINE_FETCH_H;
    assign fetch_go   = pxl_cen && (col_go || line_go);
    assign load       = pxl_cen && tile_start;

    assign map_addr = jts16_pkg::MAP_BASE + jts16_pkg::sdram_addr_t'(fline[8:3]) * MAP_W
                    + jts16_pkg::sdram_addr_t'(fcol);
    // code*8 plus the row inside the tile
    assign gfx_addr = jts16_pkg::GFX_BASE + jts16_pkg::sdram_addr_t'({code, fline[2:0]});

    assign rom_req = {cs, addr};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cs      <= 1'b0;
            step    <= 1'b0;
            map_due <= 1'b0;
            gfx_due <= 1'b0;
            drop    <= 1'b0;
            nxt_vld <= 1'b0;
        end else begin
            if (cs) begin
                if (rom_rsp.ok) begin
                    cs   <= 1'b0;
                    drop <= 1'b0;
                    if (!drop && !step) gfx_due <= 1'b1;
                    if (!drop && step) nxt_vld <= 1'b1;
                end
            end else if (!fetch_go) begin
                if (gfx_due) begin
                    cs      <= 1'b1;
                    step    <= 1'b1;
                    gfx_due <= 1'b0;
                end else if (map_due) begin
                    cs      <= 1'b1;
                    step    <= 1'b0;
                    map_due <= 1'b0;
                end
            end
            // A new tile abandons a late fetch, an in-flight word gets discarded
            if (fetch_go) begin
                map_due <= 1'b1;
                gfx_due <= 1'b0;
                drop    <= cs && !rom_rsp.ok;
            end
            if (load) nxt_vld <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_go) begin
            fcol  <= line_go ? 6'd0 : hdump[8:3] + 6'd1;
            fline <= line_go ? (vid.vb ? 9'd0 : vdump + 9'd1) : vdump;
        end
        if (!cs && !fetch_go) begin
            if (gfx_due) begin
                addr <= gfx_addr;
            end else if (map_due) begin
                addr <= map_addr;
            end
        end
        if (cs && rom_rsp.ok) begin
            if (!step) begin
                code <= rom_rsp.data[9:0];
            end else begin
                nxt_row <= rom_rsp.data;
            end
        end
        // Leftmost pixel sits in the top bits
        if (pxl_cen) begin
            if (load) begin
                shift <= nxt_vld ? {nxt_row[13:0], 2'b00} : 16'd0;
            end else begin
                shift <= {shift[13:0], 2'b00};
            end
        end
    end

    assign cur_pxl = tile_start ? (nxt_vld ? nxt_row[15:14] : 2'd0) : shift[15:14];
    assign pal_idx = (gfx_en && !vid.hb && !vid.vb) ? cur_pxl : 2'd0;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rgb      <= '0;
            LHBL_dly <= 1'b0;
            LVBL_dly <= 1'b0;
        end else if (pxl_cen) begin
            rgb      <= jts16_pkg::PALETTE[pal_idx];
            LHBL_dly <= ~vid.hb;
            LVBL_dly <= ~vid.vb;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/jts16_vtimer.sv ====
// Video timer with pixel and line counters, blanking and sync decode
`timescale 1ns/1ps
`default_nettype none

module jts16_vtimer #(
    parameter int H_ACTIVE = 64,
    parameter int H_TOTAL  = 96,
    parameter int V_ACTIVE = 32,
    parameter int V_TOTAL  = 40
) (
    input  wire             clk,
    input  wire             rst_n,
    input  wire             pxl_cen,
    output logic [8:0]      hdump,
    output logic [8:0]      vdump,
    output jts16_pkg::vid_t vid,
    output logic            LVBL
);

    localparam logic [8:0] H_LAST   = 9'(H_TOTAL - 1);
    localparam logic [8:0] V_LAST   = 9'(V_TOTAL - 1);
    localparam logic [8:0] HB_START = 9'(H_ACTIVE);
    localparam logic [8:0] VB_START = 9'(V_ACTIVE);
    // Sync pulses sit a little after the end of active video
    localparam logic [8:0] HS_START = 9'(H_ACTIVE + 8);
    localparam logic [8:0] HS_END   = 9'(H_ACTIVE + 16);
    localparam logic [8:0] VS_START = 9'(V_ACTIVE + 2);
    localparam logic [8:0] VS_END   = 9'(V_ACTIVE + 4);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hdump <= 9'd0;
            vdump <= 9'd0;
        end else if (pxl_cen) begin
            if (hdump == H_LAST) begin
                hdump <= 9'd0;
                vdump <= (vdump == V_LAST) ? 9'd0 : vdump + 9'd1;
            end else begin
                hdump <= hdump + 9'd1;
            end
        end
    end

    always_comb begin
        vid.hb = hdump >= HB_START;
        vid.vb = vdump >= VB_START;
        vid.hs = (hdump >= HS_START) && (hdump < HS_END);
        vid.vs = (vdump >= VS_START) && (vdump < VS_END);
    end

    assign LVBL = ~vid.vb;

endmodule

`default_nettype wire

// ==== rtl/jts16_cen.sv ====
// Clock-enable generator producing the double-pixel and pixel strobes from clk
`timescale 1ns/1ps
`default_nettype none

module jts16_cen (
    input  wire  clk,
    input  wire  rst_n,
    output logic pxl2_cen,
    output logic pxl_cen
);

    logic [1:0] cnt;

    // Registered strobes, both low out of reset
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt      <= 2'd0;
            pxl2_cen <= 1'b0;
            pxl_cen  <= 1'b0;
        end else begin
            cnt      <= cnt + 2'd1;
            // One clk in two
            pxl2_cen <= cnt[0];
            // Lands on every second pxl2_cen
            pxl_cen  <= &cnt;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/jts16_pkg.sv ====
// Video subsystem package with shared types, arbiter states, SDRAM area map and palette
`default_nettype none

package jts16_pkg;

    typedef logic [21:0] sdram_addr_t;
    typedef logic [15:0] sdram_data_t;
    typedef logic [16:0] cpu_addr_t;
    typedef logic [ 1:0] pxl_t;

    typedef struct packed {
        logic [4:0] red;
        logic [4:0] green;
        logic [4:0] blue;
    } rgb_t;

    // Character layer request towards the arbiter
    typedef struct packed {
        logic        cs;
        sdram_addr_t addr;
    } rom_req_t;

    typedef struct packed {
        logic        ok;
        sdram_data_t data;
    } rom_rsp_t;

    typedef struct packed {
        logic hb;
        logic vb;
        logic hs;
        logic vs;
    } vid_t;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_CHAR,
        ST_MAIN
    } arb_st_e;

    // Word bases of tile map, tile graphics and main CPU ROM
    localparam sdram_addr_t MAP_BASE  = 22'h000000;
    localparam sdram_addr_t GFX_BASE  = 22'h010000;
    localparam sdram_addr_t MAIN_BASE = 22'h100000;

    // Entry 0 is the black backdrop, order is red, green, blue
    localparam rgb_t PALETTE [4] = '{
        '{5'd0,  5'd0,  5'd0 },
        '{5'd31, 5'd8,  5'd4 },
        '{5'd6,  5'd28, 5'd10},
        '{5'd12, 5'd14, 5'd31}
    };

endpackage

`default_nettype wire
